// File: include/sdi_rxtx_consts.svh
// Shared constants for the SDI RX/TX control blocks
// Mode code 2'b11 is not a mode of its own and is read as HD everywhere
// EVENT_FIFO_DEPTH must be a power of two and fit in CREDIT_W bits
// EVENT_W must equal 1 + 15 so that both event record views line up

`ifndef SDI_RXTX_CONSTS_SVH
`define SDI_RXTX_CONSTS_SVH

// SDI mode codes
`define SDI_MODE_HD         2'b00
`define SDI_MODE_SD         2'b01
`define SDI_MODE_3G         2'b10

// Data widths
`define LINE_W              11          // Line number
`define ERR_CNT_W           16          // Error counters
`define EVENT_W             16          // One event record

// Event buffer and its credit counter
`define EVENT_FIFO_DEPTH    8
`define CREDIT_W            4

// Ring pattern giving the 5/6/5/6 SD enable cadence
`define SD_CE_SEED          11'b00000100001

// VPID byte 2, picture rate field
`define VPID_B2_50          8'hC9
`define VPID_B2_5994        8'hCA
`define VPID_B2_60          8'hCB

`endif

// File: source/sdi_rxtx_pkg.sv
// Event record types for the RX error monitor
// Bit 15 of every record is the kind bit and selects the view
// SD view holds the EDH count already saturated to 15 bits

`default_nettype none

`include "sdi_rxtx_consts.svh"

package sdi_rxtx_pkg;

    // HD or 3G CRC error record, kind = 0
    typedef struct packed {
        logic               kind;
        logic               err_a;          // Stream A CRC error
        logic               err_b;          // Stream B CRC error (3G level B)
        logic [1:0]         rsvd;
        logic [`LINE_W-1:0] line;           // Line number of stream A
    } hd_event_s;

    // SD EDH record, kind = 1
    typedef struct packed {
        logic                kind;
        logic [`EVENT_W-2:0] edh_cnt;       // Snapshot of the EDH error count
    } sd_event_s;

    // One event word, decoded by its kind bit
    typedef union packed {
        hd_event_s hd;
        sd_event_s sd;
    } crc_event_u;

endpackage

`default_nettype wire

// File: source/tx_format_control.sv
// TX clock enables and format legalization
// tx_sd_ce and tx_ce lag the cadence ring by one register stage
// tx_fmt, tx_m, tx_vpid_byte2 and tx_insert_vpid are purely combinational
// Only formats 4 and 5 are legal in 3G mode and anything else becomes 4

`default_nettype none

`include "sdi_rxtx_consts.svh"

module tx_format_control (
    input  wire        rx_usrclk,
    input  wire        tx_fabric_reset,
    input  wire  [1:0] tx_mode_sel,
    input  wire  [2:0] tx_fmt_sel,
    input  wire        tx_bitrate_sel,
    output logic       tx_ce,
    output logic       tx_sd_ce,
    output logic [2:0] tx_fmt,
    output logic       tx_m,
    output logic [7:0] tx_vpid_byte2,
    output logic       tx_insert_vpid
);

    logic [1:0]  tx_mode;
    logic [10:0] sd_ce_ring;                // Circulating cadence pattern

    assign tx_mode = (tx_mode_sel == 2'b11) ? `SDI_MODE_HD : tx_mode_sel;

    // ------------------------------------------------------------------------
    // Clock enables
    // ------------------------------------------------------------------------
    always_ff @(posedge rx_usrclk) begin
        if (tx_fabric_reset) begin
            sd_ce_ring <= `SD_CE_SEED;
            tx_sd_ce   <= 1'b0;
            tx_ce      <= (tx_mode != `SDI_MODE_SD);
        end else begin
            sd_ce_ring <= {sd_ce_ring[9:0], sd_ce_ring[10]};
            tx_sd_ce   <= sd_ce_ring[10];
            tx_ce      <= (tx_mode == `SDI_MODE_SD) ? sd_ce_ring[10] : 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Format and rate legalization
    // ------------------------------------------------------------------------
    always_comb begin
        if (tx_mode == `SDI_MODE_3G && tx_fmt_sel[2:1] != 2'b10)
            tx_fmt = 3'd4;                  // 1080p60
        else
            tx_fmt = tx_fmt_sel;
    end

    // No 1/1.001 rate in SD, nor for the 50 Hz and 25 Hz formats
    always_comb begin
        if (tx_mode == `SDI_MODE_SD)
            tx_m = 1'b0;
        else if (tx_fmt == 3'd0 || tx_fmt == 3'd3 || tx_fmt == 3'd5)
            tx_m = 1'b0;
        else
            tx_m = tx_bitrate_sel;
    end

    always_comb begin
        if (tx_fmt[0])
            tx_vpid_byte2 = `VPID_B2_50;
        else if (tx_m)
            tx_vpid_byte2 = `VPID_B2_5994;
        else
            tx_vpid_byte2 = `VPID_B2_60;
    end

    assign tx_insert_vpid = (tx_mode == `SDI_MODE_3G);

endmodule

`default_nettype wire

// File: source/crc_event_capture.sv
// Turns CRC error strobes and EDH count changes into event records
// push follows the error input by two cycles (input register, edge detect)
// A record is sent only with rx_mode_locked high and at least one credit
// An event that finds no credit is dropped and sets event_lost

`default_nettype none

`include "sdi_rxtx_consts.svh"

module crc_event_capture (
    input  wire                        rx_usrclk,
    input  wire                        tx_fabric_reset,
    input  wire  [1:0]                 rx_mode,
    input  wire                        rx_mode_locked,
    input  wire                        rx_level_b,
    input  wire                        rx_crc_err_a,
    input  wire                        rx_crc_err_b,
    input  wire  [`LINE_W-1:0]         rx_line_a,
    input  wire  [`ERR_CNT_W-1:0]      rx_edh_errcnt,
    input  wire                        clr_errs,
    input  wire                        credit_return,
    output logic                       push,
    output sdi_rxtx_pkg::crc_event_u   push_word,
    output logic                       crc_err,
    output logic                       event_lost
);

    import sdi_rxtx_pkg::*;

    logic                  err_a_q, err_b_q, err_ab_d;
    logic                  sd_q, locked_q;
    logic [`LINE_W-1:0]    line_q;
    logic [`ERR_CNT_W-1:0] edh_q, edh_d;
    logic [`EVENT_W-2:0]   edh_snap;
    logic [`CREDIT_W-1:0]  credits;
    logic                  hd_evt, sd_evt, send;
    crc_event_u            next_word;

    // ------------------------------------------------------------------------
    // Input stage and edge detection
    // ------------------------------------------------------------------------
    always_ff @(posedge rx_usrclk) begin
        if (tx_fabric_reset) begin
            err_a_q  <= 1'b0;
            err_b_q  <= 1'b0;
            err_ab_d <= 1'b0;
            sd_q     <= 1'b0;
            locked_q <= 1'b0;
            edh_q    <= '0;
            edh_d    <= '0;
        end else begin
            err_a_q  <= rx_crc_err_a;
            err_b_q  <= rx_crc_err_b & rx_level_b & (rx_mode == `SDI_MODE_3G);
            err_ab_d <= err_a_q | err_b_q;
            sd_q     <= (rx_mode == `SDI_MODE_SD);
            locked_q <= rx_mode_locked;
            edh_q    <= rx_edh_errcnt;
            edh_d    <= edh_q;
        end
    end

    always_ff @(posedge rx_usrclk)
        line_q <= rx_line_a;

    assign hd_evt   = (err_a_q | err_b_q) & ~err_ab_d & ~sd_q;  // Rising edge only
    assign sd_evt   = sd_q & (edh_q != edh_d);
    assign send     = (hd_evt | sd_evt) & locked_q & (credits != '0);
    assign edh_snap = (|edh_q[`ERR_CNT_W-1:`EVENT_W-1]) ? '1 : edh_q[`EVENT_W-2:0];

    always_comb begin
        next_word = '0;
        if (sd_q) begin
            next_word.sd.kind    = 1'b1;
            next_word.sd.edh_cnt = edh_snap;
        end else begin
            next_word.hd.kind  = 1'b0;
            next_word.hd.err_a = err_a_q;
            next_word.hd.err_b = err_b_q;
            next_word.hd.line  = line_q;
        end
    end

    // ------------------------------------------------------------------------
    // Credits, push and sticky flags
    // ------------------------------------------------------------------------
    always_ff @(posedge rx_usrclk) begin
        if (tx_fabric_reset) begin
            credits    <= `CREDIT_W'(`EVENT_FIFO_DEPTH);
            push       <= 1'b0;
            crc_err    <= 1'b0;
            event_lost <= 1'b0;
        end else begin
            push <= send;
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // Both or neither
            endcase
            if (clr_errs) begin
                crc_err    <= 1'b0;
                event_lost <= 1'b0;
            end else begin
                if (hd_evt)
                    crc_err <= 1'b1;
                if ((hd_evt | sd_evt) & locked_q & (credits == '0))
                    event_lost <= 1'b1;
            end
        end
    end

    always_ff @(posedge rx_usrclk)
        push_word <= next_word;

endmodule

`default_nettype wire

// File: source/event_fifo.sv
// Circular buffer for event records between capture and report
// No full flag since the producer's credits keep pushes within the depth
// Pushed word is visible on head_word one cycle after push
// credit_return pulses the cycle after each pop

`default_nettype none

`include "sdi_rxtx_consts.svh"

module event_fifo (
    input  wire                        rx_usrclk,
    input  wire                        tx_fabric_reset,
    input  wire                        push,
    input  wire sdi_rxtx_pkg::crc_event_u push_word,
    input  wire                        pop,
    output logic                       head_valid,
    output sdi_rxtx_pkg::crc_event_u   head_word,
    output logic                       credit_return
);

    import sdi_rxtx_pkg::*;

    localparam int PTR_W = $clog2(`EVENT_FIFO_DEPTH);

    crc_event_u           mem [`EVENT_FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr, rd_ptr;
    logic [`CREDIT_W-1:0] count;            // Occupancy
    logic                 do_pop;

    assign do_pop     = pop & head_valid;
    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];

    // ------------------------------------------------------------------------
    // Pointers, occupancy and credit pulse
    // ------------------------------------------------------------------------
    always_ff @(posedge rx_usrclk) begin
        if (tx_fabric_reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps since the depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge rx_usrclk) begin
        if (push)
            mem[wr_ptr] <= push_word;
    end

endmodule

`default_nettype wire

// File: source/err_count_report.sv
// Holds one event record for the outside reader and keeps the error count
// pop is combinational and only asked for while the slot is empty
// HD records bump a count saturating at all ones
// SD records load the EDH snapshot into err_count instead
// Count clears on clr_errs or while the receiver is not locked

`default_nettype none

`include "sdi_rxtx_consts.svh"

module err_count_report (
    input  wire                           rx_usrclk,
    input  wire                           tx_fabric_reset,
    input  wire                           head_valid,
    input  wire sdi_rxtx_pkg::crc_event_u head_word,
    input  wire                           event_pop,
    input  wire                           clr_errs,
    input  wire                           rx_mode_locked,
    output logic                          pop,
    output logic                          event_valid,
    output sdi_rxtx_pkg::crc_event_u      event_word,
    output logic [`ERR_CNT_W-1:0]         err_count
);

    import sdi_rxtx_pkg::*;

    sd_event_s head_sd;                     // SD view of the head record

    assign head_sd = head_word.sd;
    assign pop     = head_valid & ~event_valid;

    // ------------------------------------------------------------------------
    // Output slot
    // ------------------------------------------------------------------------
    always_ff @(posedge rx_usrclk) begin
        if (tx_fabric_reset)
            event_valid <= 1'b0;
        else if (pop)
            event_valid <= 1'b1;
        else if (event_pop)
            event_valid <= 1'b0;            // Ignored when already empty
    end

    always_ff @(posedge rx_usrclk) begin
        if (pop)
            event_word <= head_word;
    end

    // ------------------------------------------------------------------------
    // Error count
    // ------------------------------------------------------------------------
    always_ff @(posedge rx_usrclk) begin
        if (tx_fabric_reset) begin
            err_count <= '0;
        end else if (clr_errs || !rx_mode_locked) begin
            err_count <= '0;
        end else if (pop) begin
            if (head_word.hd.kind == 1'b0) begin
                if (err_count != '1)
                    err_count <= err_count + 1'b1;
            end else begin
                err_count <= `ERR_CNT_W'(head_sd.edh_cnt);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sdi_rxtx_ctrl.sv
// SDI RX/TX control top level on the single rx_usrclk domain
// TX format control sits beside the RX error event chain
// Error path latency is 4 cycles from strobe to event_valid without back-pressure

`default_nettype none

`include "sdi_rxtx_consts.svh"

module sdi_rxtx_ctrl (
    input  wire                        rx_usrclk,
    input  wire                        tx_fabric_reset,
    input  wire  [1:0]                 tx_mode_sel,
    input  wire  [2:0]                 tx_fmt_sel,
    input  wire                        tx_bitrate_sel,
    input  wire  [1:0]                 rx_mode,
    input  wire                        rx_mode_locked,
    input  wire                        rx_level_b,
    input  wire                        rx_crc_err_a,
    input  wire                        rx_crc_err_b,
    input  wire  [`LINE_W-1:0]         rx_line_a,
    input  wire  [`ERR_CNT_W-1:0]      rx_edh_errcnt,
    input  wire                        clr_errs,
    input  wire                        event_pop,
    output wire                        tx_ce,
    output wire                        tx_sd_ce,
    output wire  [2:0]                 tx_fmt,
    output wire                        tx_m,
    output wire  [7:0]                 tx_vpid_byte2,
    output wire                        tx_insert_vpid,
    output wire                        crc_err,
    output wire                        event_lost,
    output wire                        event_valid,
    output sdi_rxtx_pkg::crc_event_u   event_word,
    output wire  [`ERR_CNT_W-1:0]      err_count
);

    wire                        push;
    wire sdi_rxtx_pkg::crc_event_u push_word;
    wire                        credit_return;
    wire                        head_valid;
    wire sdi_rxtx_pkg::crc_event_u head_word;
    wire                        pop;

    tx_format_control u_tx_fmt (
        .rx_usrclk(rx_usrclk), .tx_fabric_reset(tx_fabric_reset),
        .tx_mode_sel(tx_mode_sel), .tx_fmt_sel(tx_fmt_sel), .tx_bitrate_sel(tx_bitrate_sel),
        .tx_ce(tx_ce), .tx_sd_ce(tx_sd_ce), .tx_fmt(tx_fmt), .tx_m(tx_m),
        .tx_vpid_byte2(tx_vpid_byte2), .tx_insert_vpid(tx_insert_vpid));

    // Producer, buffer and consumer of the error events
    crc_event_capture u_capture (
        .rx_usrclk(rx_usrclk), .tx_fabric_reset(tx_fabric_reset),
        .rx_mode(rx_mode), .rx_mode_locked(rx_mode_locked), .rx_level_b(rx_level_b),
        .rx_crc_err_a(rx_crc_err_a), .rx_crc_err_b(rx_crc_err_b), .rx_line_a(rx_line_a),
        .rx_edh_errcnt(rx_edh_errcnt), .clr_errs(clr_errs), .credit_return(credit_return),
        .push(push), .push_word(push_word), .crc_err(crc_err), .event_lost(event_lost));

    event_fifo u_fifo (
        .rx_usrclk(rx_usrclk), .tx_fabric_reset(tx_fabric_reset),
        .push(push), .push_word(push_word), .pop(pop),
        .head_valid(head_valid), .head_word(head_word), .credit_return(credit_return));

    err_count_report u_report (
        .rx_usrclk(rx_usrclk), .tx_fabric_reset(tx_fabric_reset),
        .head_valid(head_valid), .head_word(head_word), .event_pop(event_pop),
        .clr_errs(clr_errs), .rx_mode_locked(rx_mode_locked), .pop(pop),
        .event_valid(event_valid), .event_word(event_word), .err_count(err_count));

endmodule

`default_nettype wire

// File: testbench/tb_sdi_rxtx_ctrl.sv
// Testbench for the SDI RX/TX control top level
// Inputs change on the rising edge and outputs are sampled on the following one
// Expected TX fields and event records come from ref_tx and ref_event
// event_pop is held high except in the back-pressure test

`default_nettype none

`include "sdi_rxtx_consts.svh"

module tb_sdi_rxtx_ctrl;

    import sdi_rxtx_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int N_HD          = 24;
    localparam int N_SD          = 10;
    localparam int N_BP          = 12;
    localparam int RUN_CYCLES    = 12 + 192 + 142 + (N_HD * 4 + 42) + N_SD * 24
                                   + (N_BP * 4 + 80) + 60;
    localparam int MARGIN_CYCLES = 200;

    logic                  rx_usrclk, tx_fabric_reset;
    logic [1:0]            tx_mode_sel, rx_mode;
    logic [2:0]            tx_fmt_sel;
    logic                  tx_bitrate_sel, rx_mode_locked, rx_level_b;
    logic                  rx_crc_err_a, rx_crc_err_b, clr_errs, event_pop;
    logic [`LINE_W-1:0]    rx_line_a;
    logic [`ERR_CNT_W-1:0] rx_edh_errcnt;
    logic                  tx_ce, tx_sd_ce, tx_m, tx_insert_vpid;
    logic [2:0]            tx_fmt;
    logic [7:0]            tx_vpid_byte2;
    logic                  crc_err, event_lost, event_valid;
    crc_event_u            event_word;
    logic [`ERR_CNT_W-1:0] err_count;

    logic [`EVENT_W-1:0]   exp_q [$];          // Records still owed by the DUT
    logic [31:0]           rng;
    int                    errors, checks, cmp_errors, cmp_checks;
    int                    tests, failed_tests, errs_at_start;

    sdi_rxtx_ctrl dut (.*);

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Returns {tx_fmt, tx_m, tx_vpid_byte2, tx_insert_vpid}
    function automatic logic [12:0] ref_tx(input logic [1:0] mode_sel,
                                           input logic [2:0] fmt_sel, input logic bitrate);
        logic [1:0] mode;
        logic [2:0] fmt;
        logic       m;
        logic [7:0] b2;
        mode = (mode_sel == 2'b11) ? `SDI_MODE_HD : mode_sel;
        fmt  = (mode == `SDI_MODE_3G && fmt_sel != 3'd4 && fmt_sel != 3'd5) ? 3'd4 : fmt_sel;
        m    = (mode == `SDI_MODE_SD || fmt == 3'd0 || fmt == 3'd3 || fmt == 3'd5) ? 1'b0
                                                                                  : bitrate;
        b2   = fmt[0] ? `VPID_B2_50 : (m ? `VPID_B2_5994 : `VPID_B2_60);
        return {fmt, m, b2, mode == `SDI_MODE_3G};
    endfunction

    function automatic logic [`EVENT_W-1:0] ref_event(input logic [1:0] mode,
            input logic level_b, input logic a, input logic b,
            input logic [`LINE_W-1:0] line, input logic [`ERR_CNT_W-1:0] edh);
        logic [`EVENT_W-2:0] snap;
        snap = (edh > 16'h7FFF) ? '1 : edh[`EVENT_W-2:0];   // Saturate to 15 bits
        if (mode == `SDI_MODE_SD)
            return {1'b1, snap};
        return {1'b0, a, b & level_b & (mode == `SDI_MODE_3G), 2'b00, line};
    endfunction

    function automatic string describe(input crc_event_u w);
        if (w.hd.kind)
            return $sformatf("SD edh=%0d", w.sd.edh_cnt);
        return $sformatf("HD a=%b b=%b line=%0d", w.hd.err_a, w.hd.err_b, w.hd.line);
    endfunction

    // ------------------------------------------------------------------------
    // Clock, watchdog and comparing process
    // ------------------------------------------------------------------------
    initial begin
        rx_usrclk = 1'b0;
        forever #(CLK_PERIOD / 2) rx_usrclk = ~rx_usrclk;
    end

    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
        $display("Run timed out after %0d cycles before all tests finished",
                 RUN_CYCLES + MARGIN_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    always @(posedge rx_usrclk) begin : compare
        logic [12:0]         exp_tx;
        logic [`EVENT_W-1:0] exp_w;
        if (!tx_fabric_reset) begin
            exp_tx = ref_tx(tx_mode_sel, tx_fmt_sel, tx_bitrate_sel);
            cmp_checks++;
            if ({tx_fmt, tx_m, tx_vpid_byte2, tx_insert_vpid} !== exp_tx) begin
                $display("ERR %0t: TX mode %0d fmt %0d rate %b gave %h, expected %h", $time,
                         tx_mode_sel, tx_fmt_sel, tx_bitrate_sel,
                         {tx_fmt, tx_m, tx_vpid_byte2, tx_insert_vpid}, exp_tx);
                cmp_errors++;
            end
            if (event_valid && event_pop) begin     // Slot read on this edge
                if (exp_q.size() == 0) begin
                    $display("ERR %0t: record %s with none expected", $time,
                             describe(event_word));
                    cmp_errors++;
                end else begin
                    exp_w = exp_q.pop_front();
                    cmp_checks++;
                    if (event_word !== exp_w) begin
                        $display("ERR %0t: record %s, expected %s", $time,
                                 describe(event_word), describe(exp_w));
                        cmp_errors++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic tick(input int n);
        repeat (n) @(posedge rx_usrclk);
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One-cycle CRC strobe with a random line, then three quiet cycles
    task automatic strobe_crc(input logic [1:0] mode, input logic level_b, input logic a,
                              input logic b, input logic kept);
        logic [`LINE_W-1:0] line;
        rng  = xorshift32(rng);
        line = rng[`LINE_W-1:0];
        @(posedge rx_usrclk);
        rx_mode      <= mode;
        rx_level_b   <= level_b;
        rx_crc_err_a <= a;
        rx_crc_err_b <= b;
        rx_line_a    <= line;
        if (kept)
            exp_q.push_back(ref_event(mode, level_b, a, b, line, rx_edh_errcnt));
        @(posedge rx_usrclk);
        rx_crc_err_a <= 1'b0;
        rx_crc_err_b <= 1'b0;
        tick(2);
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge rx_usrclk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected records never came out of the DUT by %0t",
                     exp_q.size(), $time);
            errors++;
        end
        tick(2);
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + cmp_errors;
        tests++;
        if (total == errs_at_start) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", tests, name, total - errs_at_start);
        end
        errs_at_start = total;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin
        int                  last, gap, gap_prev, pulses;
        logic [1:0]          mode;
        logic                a, b, lb;
        logic [`ERR_CNT_W-1:0] edh;
        logic [`EVENT_W-1:0] exp_w;
        rng             = 32'h1dccf1a8;
        errors          = 0;
        checks          = 0;
        cmp_errors      = 0;
        cmp_checks      = 0;
        tests           = 0;
        failed_tests    = 0;
        errs_at_start   = 0;
        tx_fabric_reset <= 1'b1;
        tx_mode_sel     <= `SDI_MODE_HD;
        tx_fmt_sel      <= 3'd0;
        tx_bitrate_sel  <= 1'b0;
        rx_mode         <= `SDI_MODE_HD;
        rx_mode_locked  <= 1'b1;
        rx_level_b      <= 1'b0;
        rx_crc_err_a    <= 1'b0;
        rx_crc_err_b    <= 1'b0;
        rx_line_a       <= '0;
        rx_edh_errcnt   <= '0;
        clr_errs        <= 1'b0;
        event_pop       <= 1'b1;
        tick(10);
        tx_fabric_reset <= 1'b0;
        tick(2);

        // Every TX selection, then random ones, checked by the compare process
        for (int i = 0; i < 64 + 32; i++) begin
            rng = xorshift32(rng);
            @(posedge rx_usrclk);
            {tx_mode_sel, tx_fmt_sel, tx_bitrate_sel} <= (i < 64) ? i[5:0] : rng[5:0];
            tick(1);
        end
        end_test("TX format legalization");

        @(posedge rx_usrclk);
        tx_mode_sel <= `SDI_MODE_SD;
        tick(2);
        last     = -1;
        gap_prev = 0;
        pulses   = 0;
        for (int c = 0; c < 70; c++) begin
            @(posedge rx_usrclk);
            expect_equal("tx_ce in SD mode", 32'(tx_ce), 32'(tx_sd_ce));
            if (tx_sd_ce) begin
                gap = c - last;
                if (last >= 0 && ((gap != 5 && gap != 6) || gap == gap_prev)) begin
                    $display("ERR %0t: SD enable gap of %0d after %0d", $time, gap, gap_prev);
                    errors++;
                end
                gap_prev = (last >= 0) ? gap : 0;
                last     = c;
                pulses++;
            end
        end
        if (pulses < 12) begin
            $display("Only %0d SD enable pulses seen in 70 cycles", pulses);
            errors++;
        end
        for (int k = 0; k < 3; k++) begin   // HD, 3G, and code 11 read as HD
            @(posedge rx_usrclk);
            tx_mode_sel <= (k == 0) ? `SDI_MODE_HD : ((k == 1) ? `SDI_MODE_3G : 2'b11);
            tick(2);
            repeat (20) begin
                @(posedge rx_usrclk);
                expect_equal("tx_ce outside SD mode", 32'(tx_ce), 1);
            end
        end
        end_test("TX clock enables");

        for (int i = 0; i < N_HD; i++) begin
            rng  = xorshift32(rng);
            mode = rng[0] ? `SDI_MODE_3G : `SDI_MODE_HD;
            lb   = rng[1];
            b    = rng[2];
            a    = rng[3] | ~(b & lb & (mode == `SDI_MODE_3G));  // Combined error must rise
            strobe_crc(mode, lb, a, b, 1'b1);
        end
        wait_drained(40);
        expect_equal("err_count after HD and 3G errors", 32'(err_count), N_HD);
        expect_equal("crc_err after HD and 3G errors", 32'(crc_err), 1);
        end_test("HD and 3G CRC records");

        @(posedge rx_usrclk);
        rx_mode <= `SDI_MODE_SD;
        tick(3);
        edh = '0;
        for (int i = 0; i < N_SD; i++) begin
            rng = xorshift32(rng);
            edh = (rng[15:0] == edh) ? ~edh : rng[15:0];
            exp_w = ref_event(`SDI_MODE_SD, 1'b0, 1'b0, 1'b0, '0, edh);
            @(posedge rx_usrclk);
            rx_edh_errcnt <= edh;
            exp_q.push_back(exp_w);
            tick(1);
            wait_drained(20);
            expect_equal("err_count after an EDH change", 32'(err_count),
                         32'(exp_w[`EVENT_W-2:0]));
        end
        end_test("SD EDH records");

        // Reader stalled, only the buffer and the output slot keep records
        @(posedge rx_usrclk);
        event_pop <= 1'b0;
        for (int i = 0; i < N_BP; i++)
            strobe_crc(`SDI_MODE_HD, 1'b0, 1'b1, 1'b0, i < `EVENT_FIFO_DEPTH + 1);
        tick(8);
        expect_equal("event_lost with the reader stalled", 32'(event_lost), 1);
        @(posedge rx_usrclk);
        event_pop <= 1'b1;
        wait_drained(60);
        tick(6);
        expect_equal("event_valid after the kept records", 32'(event_valid), 0);
        end_test("Back-pressure");

        @(posedge rx_usrclk);
        clr_errs <= 1'b1;
        @(posedge rx_usrclk);
        clr_errs <= 1'b0;
        tick(2);
        expect_equal("crc_err after clear", 32'(crc_err), 0);
        expect_equal("event_lost after clear", 32'(event_lost), 0);
        expect_equal("err_count after clear", 32'(err_count), 0);
        strobe_crc(`SDI_MODE_HD, 1'b0, 1'b1, 1'b0, 1'b1);
        strobe_crc(`SDI_MODE_HD, 1'b0, 1'b1, 1'b0, 1'b1);
        wait_drained(30);
        expect_equal("err_count after two new errors", 32'(err_count), 2);
        @(posedge rx_usrclk);
        rx_mode_locked <= 1'b0;
        tick(2);
        expect_equal("err_count while unlocked", 32'(err_count), 0);
        @(posedge rx_usrclk);
        rx_mode_locked <= 1'b1;
        tick(2);
        end_test("Clearing");

        $display("Tests %0d, with errors %0d, checks %0d, errors %0d", tests, failed_tests,
                 checks + cmp_checks, errors + cmp_errors);
        if (errors + cmp_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sdi_rxtx_ctrl.f
+incdir+include
source/sdi_rxtx_pkg.sv
source/tx_format_control.sv
source/crc_event_capture.sv
source/event_fifo.sv
source/err_count_report.sv
source/sdi_rxtx_ctrl.sv
testbench/tb_sdi_rxtx_ctrl.sv

// File: Makefile
# Verilator build and run for the SDI RX/TX control testbench

VERILATOR  ?= verilator
TOP        := tb_sdi_rxtx_ctrl
DUT_TOP    := sdi_rxtx_ctrl
FILELIST   := sdi_rxtx_ctrl.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --top-module $(DUT_TOP)
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
